// ==== exu.f ====
+incdir+logic
+incdir+test
logic/exu_pkg.sv
logic/exu_cmd_queue.sv
logic/exu_ialu.sv
logic/exu_pc_ctrl.sv
logic/exu_retire.sv
logic/exu_wfi_ctrl.sv
logic/exu_top.sv
test/exu_tb.sv

// ==== test/exu_tb_tasks.svh ====
// --------------------
// EXU directed tests
// Command drivers, ALU reference and per-test checks
// --------------------

task automatic report_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    errors    = errors + 1;
    test_errs = test_errs + 1;
endtask

task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errors    = errors + 1;
    test_errs = test_errs + 1;
endtask

task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
endtask

task automatic end_test;
    tests_run = tests_run + 1;
    $display("%s finished with %0d mismatches", test_name, test_errs);
endtask

// --------------------
// Command drivers
// --------------------
task automatic start_cmd;
    @(posedge clk);
    cmd_alu_cmd  <= `EXU_ALU_ADD;                   // Plain ADD, no write
    cmd_op2_imm  <= 1'b0;
    cmd_sum2_pc  <= 1'b0;
    cmd_wb_sel   <= `EXU_WB_NONE;
    cmd_jump     <= 1'b0;
    cmd_branch   <= 1'b0;
    cmd_fencei   <= 1'b0;
    cmd_wfi      <= 1'b0;
    cmd_exc      <= 1'b0;
    cmd_exc_code <= '0;
    cmd_rs1_addr <= '0;
    cmd_rs2_addr <= '0;
    cmd_rd_addr  <= '0;
    cmd_imm      <= '0;
    idu_req      <= 1'b1;
endtask

// Accept edge, then sample in the middle of the retire cycle
task automatic retire_cmd;
    @(posedge clk);
    idu_req <= 1'b0;
    @(negedge clk);
endtask

task automatic check_retire(input logic redirect, input xlen_t target);
    if (instret !== 1'b1) report_mismatch("instret", 1'b1, instret);
    if (curr_pc !== ref_pc) report_mismatch("curr_pc", ref_pc, curr_pc);
    if (new_pc_req !== redirect) report_mismatch("new_pc_req", redirect, new_pc_req);
    if (redirect && new_pc !== target) report_mismatch("new_pc", target, new_pc);
    ref_pc = redirect ? target : ref_pc + `EXU_INSN_BYTES;
endtask

function automatic xlen_t alu_model(input alu_cmd_t op, input xlen_t a, input xlen_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        `EXU_ALU_ADD:  return a + b;
        `EXU_ALU_SUB:  return a - b;
        `EXU_ALU_AND:  return a & b;
        `EXU_ALU_OR:   return a | b;
        `EXU_ALU_XOR:  return a ^ b;
        `EXU_ALU_SLL:  return a << sh;
        `EXU_ALU_SRL:  return a >> sh;
        `EXU_ALU_SRA:  return $signed(a) >>> sh;
        `EXU_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `EXU_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default:       return '0;
    endcase
endfunction

// --------------------
// Tests
// --------------------
task automatic reset_exit_test;
    int pulses;
    int pulse_edge;
    begin_test("reset_exit");
    pulses     = 0;
    pulse_edge = 0;
    for (int e = 1; e <= 6; e++) begin
        @(posedge clk);
        @(negedge clk);
        if (new_pc_req === 1'b1) begin
            pulses     = pulses + 1;
            pulse_edge = e;
            if (new_pc !== `EXU_RST_VECTOR) report_mismatch("new_pc", `EXU_RST_VECTOR, new_pc);
        end
        if (init_pc !== (e == 3)) report_mismatch("init_pc", e == 3, init_pc);
        if ({instret, rd_w_req, exc_req} !== 3'b000) begin
            report_mismatch("retire strobes", 3'b000, {instret, rd_w_req, exc_req});
        end
    end
    if (pulses != 1 || pulse_edge != 3) begin
        report_failure("the init redirect did not pulse once after the third edge");
    end
    if (curr_pc !== `EXU_RST_VECTOR) report_mismatch("curr_pc", `EXU_RST_VECTOR, curr_pc);
    end_test();
endtask

task automatic alu_test;
    alu_cmd_t  op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_imm;
    wb_sel_t   wb;
    xlen_t     imm;
    xlen_t     exp;
    begin_test("alu");
    for (int n = 0; n < 20; n++) begin
        op        = alu_cmd_t'($unsigned($random(seed)) % 10);
        rs1       = reg_addr_t'(1 + $unsigned($random(seed)) % 15);    // Sources x1..x15
        rs2       = reg_addr_t'(1 + $unsigned($random(seed)) % 15);
        rd        = reg_addr_t'(16 + $unsigned($random(seed)) % 16);   // Never a source
        use_imm   = ($random(seed) % 2) != 0;
        imm       = $random(seed);
        wb        = (n % 5 == 4) ? `EXU_WB_NONE : `EXU_WB_IALU;
        regs[rs1] = $random(seed);
        regs[rs2] = $random(seed);
        exp       = alu_model(op, regs[rs1], use_imm ? imm : regs[rs2]);
        start_cmd();
        cmd_alu_cmd  <= op;
        cmd_op2_imm  <= use_imm;
        cmd_wb_sel   <= wb;
        cmd_rs1_addr <= rs1;
        cmd_rs2_addr <= rs2;
        cmd_rd_addr  <= rd;
        cmd_imm      <= imm;
        retire_cmd();
        if (rd_w_req !== (wb != `EXU_WB_NONE)) report_mismatch("rd_w_req", wb != 0, rd_w_req);
        if (wb != `EXU_WB_NONE && rd_data !== exp) report_mismatch("rd_data", exp, rd_data);
        if (wb != `EXU_WB_NONE && rd_addr !== rd) report_mismatch("rd_addr", rd, rd_addr);
        if (exc_req !== 1'b0) report_mismatch("exc_req", 1'b0, exc_req);
        if (instret_nexc !== 1'b1) report_mismatch("instret_nexc", 1'b1, instret_nexc);
        check_retire(1'b0, '0);
    end
    end_test();
endtask

task automatic control_flow_test;
    xlen_t target;
    begin_test("control_flow");
    regs[1] = 32'h1234_5678;
    regs[2] = 32'h1234_5678;
    regs[3] = 32'h0000_0800;
    // Taken BEQ with an odd offset, a wrong-path ADD offered behind it
    target = (ref_pc + 32'd17) & ~32'd1;
    start_cmd();
    cmd_alu_cmd  <= `EXU_ALU_EQ;
    cmd_sum2_pc  <= 1'b1;
    cmd_branch   <= 1'b1;
    cmd_rs1_addr <= 5'd1;
    cmd_rs2_addr <= 5'd2;
    cmd_imm      <= 32'd17;
    @(posedge clk);
    cmd_alu_cmd  <= `EXU_ALU_ADD;                   // idu_req stays high
    cmd_sum2_pc  <= 1'b0;
    cmd_branch   <= 1'b0;
    cmd_wb_sel   <= `EXU_WB_IALU;
    cmd_rd_addr  <= 5'd22;
    @(negedge clk);
    check_retire(1'b1, target);
    @(posedge clk);
    idu_req <= 1'b0;
    @(negedge clk);
    if (instret !== 1'b0) report_mismatch("wrong-path instret", 1'b0, instret);
    if (rd_w_req !== 1'b0) report_mismatch("wrong-path rd_w_req", 1'b0, rd_w_req);
    if (rs1_addr !== 5'd0) report_mismatch("wrong-path rs1_addr", 32'd0, rs1_addr);
    if (rs2_addr !== 5'd0) report_mismatch("wrong-path rs2_addr", 32'd0, rs2_addr);
    // BNE on equal values
    start_cmd();
    cmd_alu_cmd  <= `EXU_ALU_NE;
    cmd_sum2_pc  <= 1'b1;
    cmd_branch   <= 1'b1;
    cmd_rs1_addr <= 5'd1;
    cmd_rs2_addr <= 5'd2;
    cmd_imm      <= 32'd64;
    retire_cmd();
    check_retire(1'b0, '0);
    // JALR off x3
    target = (regs[3] + 32'h21) & ~32'd1;
    start_cmd();
    cmd_jump     <= 1'b1;
    cmd_wb_sel   <= `EXU_WB_INC_PC;
    cmd_rs1_addr <= 5'd3;
    cmd_rd_addr  <= 5'd20;
    cmd_imm      <= 32'h21;
    retire_cmd();
    if (rd_w_req !== 1'b1) report_mismatch("link rd_w_req", 1'b1, rd_w_req);
    if (rd_data !== ref_pc + 32'd4) report_mismatch("link rd_data", ref_pc + 32'd4, rd_data);
    check_retire(1'b1, target);
    start_cmd();
    cmd_fencei <= 1'b1;
    retire_cmd();
    check_retire(1'b1, ref_pc + 32'd4);
    end_test();
endtask

task automatic exception_test;
    xlen_t bits;
    xlen_t target;
    begin_test("exception");
    bits = $random(seed);
    start_cmd();
    cmd_exc      <= 1'b1;
    cmd_exc_code <= `EXU_EXC_ILLEGAL;
    cmd_imm      <= bits;
    cmd_wb_sel   <= `EXU_WB_IALU;
    cmd_rd_addr  <= 5'd21;
    retire_cmd();
    if (exc_req !== 1'b1) report_mismatch("illegal exc_req", 1'b1, exc_req);
    if (exc_code !== `EXU_EXC_ILLEGAL) report_mismatch("illegal code", 4'd2, exc_code);
    if (trap_val !== bits) report_mismatch("illegal trap_val", bits, trap_val);
    if (rd_w_req !== 1'b0) report_mismatch("illegal rd_w_req", 1'b0, rd_w_req);
    if (instret_nexc !== 1'b0) report_mismatch("instret_nexc", 1'b0, instret_nexc);
    check_retire(1'b1, `EXU_TRAP_VECTOR);
    // PC-relative jump landing on bit 1
    target = ref_pc + 32'd6;
    start_cmd();
    cmd_jump    <= 1'b1;
    cmd_sum2_pc <= 1'b1;
    cmd_imm     <= 32'd6;
    cmd_wb_sel  <= `EXU_WB_INC_PC;
    cmd_rd_addr <= 5'd21;
    retire_cmd();
    if (exc_req !== 1'b1) report_mismatch("misalign exc_req", 1'b1, exc_req);
    if (exc_code !== `EXU_EXC_INSTR_MISALIGN) report_mismatch("misalign code", 4'd0, exc_code);
    if (trap_val !== target) report_mismatch("misalign trap_val", target, trap_val);
    if (rd_w_req !== 1'b0) report_mismatch("misalign rd_w_req", 1'b0, rd_w_req);
    check_retire(1'b1, `EXU_TRAP_VECTOR);
    end_test();
endtask

task automatic wfi_test;
    xlen_t wfi_pc;
    int    waited;
    begin_test("wfi");
    wfi_pc = ref_pc;
    start_cmd();
    cmd_wfi <= 1'b1;
    retire_cmd();
    if (idu_rdy !== 1'b0) report_mismatch("idu_rdy at retire", 1'b0, idu_rdy);
    check_retire(1'b0, '0);
    repeat (3) begin
        @(negedge clk);
        if (wfi_halted !== 1'b1) report_mismatch("wfi_halted", 1'b1, wfi_halted);
        if (idu_rdy !== 1'b0) report_mismatch("idu_rdy halted", 1'b0, idu_rdy);
    end
    @(posedge clk);
    irq_pending <= 1'b1;
    waited = 0;
    do begin
        @(negedge clk);
        waited = waited + 1;
    end while (new_pc_req !== 1'b1 && waited < 8);
    if (new_pc_req !== 1'b1) begin
        report_failure("no resume redirect after irq_pending was raised");
    end else if (new_pc !== wfi_pc + 32'd4) begin
        report_mismatch("resume new_pc", wfi_pc + 32'd4, new_pc);
    end
    @(negedge clk);
    if (idu_rdy !== 1'b1) report_mismatch("idu_rdy after resume", 1'b1, idu_rdy);
    if (wfi_halted !== 1'b0) report_mismatch("wfi_halted after resume", 1'b0, wfi_halted);
    @(posedge clk);
    irq_pending <= 1'b0;
    end_test();
endtask

// ==== test/exu_tb.sv ====
// --------------------
// EXU testbench
// Register file model, clock, reset and the directed test sequence
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int SEQ_CYCLES = 200;                // Directed sequence plus margin
    localparam int TIMEOUT    = 10 * SEQ_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      idu_req;
    alu_cmd_t  cmd_alu_cmd;
    logic      cmd_op2_imm;
    logic      cmd_sum2_pc;
    wb_sel_t   cmd_wb_sel;
    logic      cmd_jump;
    logic      cmd_branch;
    logic      cmd_fencei;
    logic      cmd_wfi;
    logic      cmd_exc;
    exc_code_t cmd_exc_code;
    reg_addr_t cmd_rs1_addr;
    reg_addr_t cmd_rs2_addr;
    reg_addr_t cmd_rd_addr;
    xlen_t     cmd_imm;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      irq_pending;
    logic      idu_rdy;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      rd_w_req;
    reg_addr_t rd_addr;
    xlen_t     rd_data;
    logic      exc_req;
    exc_code_t exc_code;
    xlen_t     trap_val;
    logic      instret;
    logic      instret_nexc;
    logic      init_pc;
    logic      wfi_halted;
    xlen_t     curr_pc;
    logic      new_pc_req;
    xlen_t     new_pc;

    xlen_t     regs [0:31];
    integer    seed;
    integer    errors;
    integer    test_errs;
    integer    tests_run;
    integer    cycles;
    xlen_t     ref_pc;                              // PC of the next command to retire
    string     test_name;

    exu_top exu_top_i (.*);

    always #4 clk = ~clk;                           // 8 ns period

    // --------------------
    // Register file model
    // --------------------
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always @(posedge clk) begin
        if (rd_w_req && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;               // x0 stays zero
        end
    end

    `include "exu_tb_tasks.svh"

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("Errors found");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        idu_req      = 1'b0;
        cmd_alu_cmd  = `EXU_ALU_ADD;
        cmd_op2_imm  = 1'b0;
        cmd_sum2_pc  = 1'b0;
        cmd_wb_sel   = `EXU_WB_NONE;
        cmd_jump     = 1'b0;
        cmd_branch   = 1'b0;
        cmd_fencei   = 1'b0;
        cmd_wfi      = 1'b0;
        cmd_exc      = 1'b0;
        cmd_exc_code = '0;
        cmd_rs1_addr = '0;
        cmd_rs2_addr = '0;
        cmd_rd_addr  = '0;
        cmd_imm      = '0;
        irq_pending  = 1'b0;
        seed         = 31791;
        errors       = 0;
        tests_run    = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = (i == 0) ? '0 : 32'hA500_0000 + i;
        end
        repeat (10) @(posedge clk);
        rst_n  <= 1'b1;
        ref_pc = `EXU_RST_VECTOR;
        reset_exit_test();
        alu_test();
        control_flow_test();
        exception_test();
        wfi_test();
        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed checks", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : exu_tb

// ==== logic/exu_top.sv ====
// --------------------
// EXU top level
// Execute stage of the RV32 pipeline
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               idu_req,
    input  exu_pkg::alu_cmd_t  cmd_alu_cmd,
    input  logic               cmd_op2_imm,
    input  logic               cmd_sum2_pc,
    input  exu_pkg::wb_sel_t   cmd_wb_sel,
    input  logic               cmd_jump,
    input  logic               cmd_branch,
    input  logic               cmd_fencei,
    input  logic               cmd_wfi,
    input  logic               cmd_exc,
    input  exu_pkg::exc_code_t cmd_exc_code,
    input  exu_pkg::reg_addr_t cmd_rs1_addr,
    input  exu_pkg::reg_addr_t cmd_rs2_addr,
    input  exu_pkg::reg_addr_t cmd_rd_addr,
    input  exu_pkg::xlen_t     cmd_imm,
    input  exu_pkg::xlen_t     rs1_data,
    input  exu_pkg::xlen_t     rs2_data,
    input  logic               irq_pending,
    output logic               idu_rdy,
    output exu_pkg::reg_addr_t rs1_addr,
    output exu_pkg::reg_addr_t rs2_addr,
    output logic               rd_w_req,
    output exu_pkg::reg_addr_t rd_addr,
    output exu_pkg::xlen_t     rd_data,
    output logic               exc_req,
    output exu_pkg::exc_code_t exc_code,
    output exu_pkg::xlen_t     trap_val,
    output logic               instret,
    output logic               instret_nexc,
    output logic               init_pc,
    output logic               wfi_halted,
    output exu_pkg::xlen_t     curr_pc,
    output logic               new_pc_req,
    output exu_pkg::xlen_t     new_pc
);
    import exu_pkg::*;

    // --------------------
    // Queued command
    // --------------------
    logic      q_vd;
    alu_cmd_t  q_alu_cmd;
    logic      q_op2_imm;
    logic      q_sum2_pc;
    wb_sel_t   q_wb_sel;
    logic      q_jump;
    logic      q_branch;
    logic      q_fencei;
    logic      q_wfi;
    logic      q_exc;
    exc_code_t q_exc_code;
    reg_addr_t q_rd_addr;
    xlen_t     q_imm;

    // Datapath and control
    xlen_t     alu_res;
    logic      alu_cmp;
    xlen_t     sum2_res;
    xlen_t     inc_pc;
    xlen_t     jb_target;
    logic      jb_misalign;
    logic      take_exc;
    logic      barrier;
    logic      wfi_run_start;

    exu_cmd_queue exu_cmd_queue_i (.*);

    exu_ialu      exu_ialu_i      (.*);

    exu_pc_ctrl   exu_pc_ctrl_i   (.*);

    exu_retire    exu_retire_i    (.*);

    exu_wfi_ctrl  exu_wfi_ctrl_i  (.*);

    assign exc_req = take_exc;                      // Trap already folded into new_pc

endmodule : exu_top

// ==== logic/exu_wfi_ctrl.sv ====
// --------------------
// EXU WFI control
// Halt after WFI and resume on a pending interrupt
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_wfi_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic q_vd,
    input  logic q_wfi,
    input  logic irq_pending,
    output logic barrier,
    output logic wfi_run_start,
    output logic wfi_halted
);
    import exu_pkg::*;

    wfi_state_e state;
    wfi_state_e state_nxt;
    logic       run2halt;

    assign run2halt = (state == WFI_RUN) & q_vd & q_wfi & ~irq_pending;

    always_comb begin
        state_nxt = state;
        case (state)
            WFI_RUN: begin
                if (run2halt) begin
                    state_nxt = WFI_HALTED;
                end
            end
            WFI_HALTED: begin
                if (irq_pending) begin
                    state_nxt = WFI_RESUME;
                end
            end
            default: state_nxt = WFI_RUN;           // Resume lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WFI_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign wfi_halted    = (state == WFI_HALTED);
    assign wfi_run_start = (state == WFI_RESUME);
    assign barrier       = (state != WFI_RUN) | run2halt;   // Hold off the decoder

endmodule : exu_wfi_ctrl

// ==== logic/exu_retire.sv ====
// --------------------
// EXU retirement
// Exceptions, trap value and register write-back
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_retire (
    input  logic               q_vd,
    input  logic               q_exc,
    input  exu_pkg::exc_code_t q_exc_code,
    input  exu_pkg::wb_sel_t   q_wb_sel,
    input  exu_pkg::reg_addr_t q_rd_addr,
    input  exu_pkg::xlen_t     q_imm,
    input  logic               jb_misalign,
    input  exu_pkg::xlen_t     jb_target,
    input  exu_pkg::xlen_t     alu_res,
    input  exu_pkg::xlen_t     sum2_res,
    input  exu_pkg::xlen_t     inc_pc,
    output logic               take_exc,
    output exu_pkg::exc_code_t exc_code,
    output exu_pkg::xlen_t     trap_val,
    output logic               instret,
    output logic               instret_nexc,
    output logic               rd_w_req,
    output exu_pkg::reg_addr_t rd_addr,
    output exu_pkg::xlen_t     rd_data
);

    // --------------------
    // Exceptions
    // --------------------
    assign take_exc = (q_vd & q_exc) | jb_misalign;

    always_comb begin
        if (q_exc) begin
            exc_code = q_exc_code;                  // Decoder fault wins
        end else begin
            exc_code = `EXU_EXC_INSTR_MISALIGN;
        end
        case (exc_code)
            `EXU_EXC_INSTR_MISALIGN: trap_val = jb_target;
            `EXU_EXC_ILLEGAL:        trap_val = q_imm;    // Instruction bits
            `EXU_EXC_BREAKPOINT,
            `EXU_EXC_ECALL:          trap_val = '0;
            default:                 trap_val = '0;
        endcase
    end

    assign instret      = q_vd;                     // Every valid command retires
    assign instret_nexc = instret & ~take_exc;

    // --------------------
    // Write-back
    // --------------------
    assign rd_w_req = q_vd & ~take_exc & (q_wb_sel != `EXU_WB_NONE);
    assign rd_addr  = q_rd_addr;

    always_comb begin
        case (q_wb_sel)
            `EXU_WB_SUM2:   rd_data = sum2_res;
            `EXU_WB_IMM:    rd_data = q_imm;        // LUI
            `EXU_WB_INC_PC: rd_data = inc_pc;       // Link address
            `EXU_WB_IALU:   rd_data = alu_res;
            default:        rd_data = alu_res;
        endcase
    end

    // A misaligned target from PC control must only come with a valid command
    always_comb begin
        exc_needs_vd: assert final (q_vd || !take_exc)
            else $error("exu_retire: exception without a valid command");
    end

endmodule : exu_retire

// ==== logic/exu_pc_ctrl.sv ====
// --------------------
// EXU PC control
// Reset exit, current PC and redirect selection
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_pc_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           q_vd,
    input  logic           q_jump,
    input  logic           q_branch,
    input  logic           q_fencei,
    input  logic           alu_cmp,
    input  exu_pkg::xlen_t sum2_res,
    input  logic           take_exc,
    input  logic           wfi_run_start,
    input  logic           instret,
    output exu_pkg::xlen_t curr_pc,
    output exu_pkg::xlen_t inc_pc,
    output exu_pkg::xlen_t jb_target,
    output logic           jb_misalign,
    output logic           new_pc_req,
    output exu_pkg::xlen_t new_pc,
    output logic           init_pc
);
    import exu_pkg::*;

    localparam int INIT_D = `EXU_INIT_DEPTH;

    logic [INIT_D-1:0] init_v;
    logic              jb_taken;
    logic              fencei_vd;

    // --------------------
    // Reset exit
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_v <= '0;
        end else if (!(&init_v)) begin
            init_v <= {init_v[INIT_D-2:0], 1'b1};   // One stage per edge
        end
    end

    assign init_pc = init_v[INIT_D-2] & ~init_v[INIT_D-1];

    // --------------------
    // Redirect decision
    // --------------------
    assign inc_pc      = curr_pc + xlen_t'(`EXU_INSN_BYTES);
    assign jb_target   = {sum2_res[`EXU_XLEN-1:1], 1'b0};
    assign jb_taken    = q_vd & (q_jump | (q_branch & alu_cmp));
    assign jb_misalign = jb_taken & jb_target[1];   // No compressed support
    assign fencei_vd   = q_vd & q_fencei;

    assign new_pc_req = init_pc | take_exc | fencei_vd | wfi_run_start | jb_taken;

    always_comb begin
        if (init_pc) begin
            new_pc = `EXU_RST_VECTOR;
        end else if (take_exc) begin
            new_pc = `EXU_TRAP_VECTOR;
        end else if (wfi_run_start) begin
            new_pc = curr_pc;                       // Refetch after WFI
        end else if (fencei_vd) begin
            new_pc = inc_pc;
        end else begin
            new_pc = jb_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= `EXU_RST_VECTOR;
        end else if (instret) begin
            curr_pc <= new_pc_req ? new_pc : inc_pc;
        end
    end

    // Fetch only ever sees word-aligned targets
    new_pc_even: assert property (@(posedge clk) disable iff (!rst_n)
        new_pc_req |-> (new_pc[1:0] == 2'b00))
        else $error("exu_pc_ctrl: misaligned new_pc on redirect");

endmodule : exu_pc_ctrl

// ==== logic/exu_ialu.sv ====
// --------------------
// EXU integer ALU
// Operand select, ALU, branch compare and address adder
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_ialu (
    input  exu_pkg::alu_cmd_t q_alu_cmd,
    input  logic              q_op2_imm,
    input  logic              q_sum2_pc,
    input  exu_pkg::xlen_t    rs1_data,
    input  exu_pkg::xlen_t    rs2_data,
    input  exu_pkg::xlen_t    q_imm,
    input  exu_pkg::xlen_t    curr_pc,
    output exu_pkg::xlen_t    alu_res,
    output logic              alu_cmp,
    output exu_pkg::xlen_t    sum2_res
);
    import exu_pkg::*;

    xlen_t                        op2;
    logic [$clog2(`EXU_XLEN)-1:0] shamt;
    logic                         eq;
    logic                         lt_s;
    logic                         lt_u;

    // --------------------
    // Operands and flags
    // --------------------
    assign op2   = q_op2_imm ? q_imm : rs2_data;
    assign shamt = op2[$clog2(`EXU_XLEN)-1:0];      // Low five bits only
    assign eq    = (rs1_data == op2);
    assign lt_u  = (rs1_data < op2);
    assign lt_s  = ($signed(rs1_data) < $signed(op2));

    always_comb begin
        case (q_alu_cmd)
            `EXU_ALU_ADD:  alu_res = rs1_data + op2;
            `EXU_ALU_SUB:  alu_res = rs1_data - op2;
            `EXU_ALU_AND:  alu_res = rs1_data & op2;
            `EXU_ALU_OR:   alu_res = rs1_data | op2;
            `EXU_ALU_XOR:  alu_res = rs1_data ^ op2;
            `EXU_ALU_SLL:  alu_res = rs1_data << shamt;
            `EXU_ALU_SRL:  alu_res = rs1_data >> shamt;
            `EXU_ALU_SRA:  alu_res = xlen_t'($signed(rs1_data) >>> shamt);
            `EXU_ALU_SLT:  alu_res = xlen_t'(lt_s);
            `EXU_ALU_SLTU: alu_res = xlen_t'(lt_u);
            default:       alu_res = '0;            // Compare commands
        endcase
    end

    // Branch comparator
    always_comb begin
        case (q_alu_cmd)
            `EXU_ALU_EQ:  alu_cmp = eq;
            `EXU_ALU_NE:  alu_cmp = ~eq;
            `EXU_ALU_LT:  alu_cmp = lt_s;
            `EXU_ALU_GE:  alu_cmp = ~lt_s;
            `EXU_ALU_LTU: alu_cmp = lt_u;
            `EXU_ALU_GEU: alu_cmp = ~lt_u;
            default:      alu_cmp = 1'b0;
        endcase
    end

    // Address adder for jumps, branches and AUIPC
    assign sum2_res = (q_sum2_pc ? curr_pc : rs1_data) + q_imm;

endmodule : exu_ialu

// ==== logic/exu_cmd_queue.sv ====
// --------------------
// EXU command queue
// One-entry holding register for the decoder command
// --------------------
`timescale 1ns/100ps
`include "exu_params.svh"

module exu_cmd_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               idu_req,
    input  exu_pkg::alu_cmd_t  cmd_alu_cmd,
    input  logic               cmd_op2_imm,
    input  logic               cmd_sum2_pc,
    input  exu_pkg::wb_sel_t   cmd_wb_sel,
    input  logic               cmd_jump,
    input  logic               cmd_branch,
    input  logic               cmd_fencei,
    input  logic               cmd_wfi,
    input  logic               cmd_exc,
    input  exu_pkg::exc_code_t cmd_exc_code,
    input  exu_pkg::reg_addr_t cmd_rs1_addr,
    input  exu_pkg::reg_addr_t cmd_rs2_addr,
    input  exu_pkg::reg_addr_t cmd_rd_addr,
    input  exu_pkg::xlen_t     cmd_imm,
    input  logic               barrier,
    input  logic               new_pc_req,
    output logic               idu_rdy,
    output logic               q_vd,
    output exu_pkg::alu_cmd_t  q_alu_cmd,
    output logic               q_op2_imm,
    output logic               q_sum2_pc,
    output exu_pkg::wb_sel_t   q_wb_sel,
    output logic               q_jump,
    output logic               q_branch,
    output logic               q_fencei,
    output logic               q_wfi,
    output logic               q_exc,
    output exu_pkg::exc_code_t q_exc_code,
    output exu_pkg::reg_addr_t q_rd_addr,
    output exu_pkg::xlen_t     q_imm,
    output exu_pkg::reg_addr_t rs1_addr,
    output exu_pkg::reg_addr_t rs2_addr
);
    import exu_pkg::*;

    reg_addr_t q_rs1_addr;
    reg_addr_t q_rs2_addr;
    logic      accept;

    assign idu_rdy = ~barrier;                  // Execution never stalls by itself
    assign accept  = idu_req & idu_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_vd <= 1'b0;
        end else if (barrier) begin
            q_vd <= 1'b0;
        end else begin
            q_vd <= idu_req & ~new_pc_req;      // Wrong-path fetch is dropped
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (accept) begin
            q_alu_cmd  <= cmd_alu_cmd;
            q_op2_imm  <= cmd_op2_imm;
            q_sum2_pc  <= cmd_sum2_pc;
            q_wb_sel   <= cmd_wb_sel;
            q_jump     <= cmd_jump;
            q_branch   <= cmd_branch;
            q_fencei   <= cmd_fencei;
            q_wfi      <= cmd_wfi;
            q_exc      <= cmd_exc;
            q_exc_code <= cmd_exc_code;
            q_rs1_addr <= cmd_rs1_addr;
            q_rs2_addr <= cmd_rs2_addr;
            q_rd_addr  <= cmd_rd_addr;
            q_imm      <= cmd_imm;
        end
    end

    assign rs1_addr = q_vd ? q_rs1_addr : '0;   // Idle register file reads x0
    assign rs2_addr = q_vd ? q_rs2_addr : '0;

    // Decoder must never mark a command as both jump and branch
    jump_branch_excl: assert property (@(posedge clk) disable iff (!rst_n)
        q_vd |-> !(q_jump && q_branch))
        else $error("exu_cmd_queue: jump and branch both set");

endmodule : exu_cmd_queue

// ==== logic/exu_pkg.sv ====
// --------------------
// EXU shared types
// Datapath words, command fields and WFI states
// --------------------
`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]       xlen_t;         // Data or PC word
    typedef logic [`EXU_REG_AWIDTH-1:0] reg_addr_t;     // Register index
    typedef logic [3:0]                 alu_cmd_t;
    typedef logic [2:0]                 wb_sel_t;
    typedef logic [3:0]                 exc_code_t;

    // WFI halt sequencing
    typedef enum logic [1:0] {
        WFI_RUN,
        WFI_HALTED,
        WFI_RESUME                                      // One refetch cycle before run
    } wfi_state_e;

endpackage : exu_pkg

// ==== logic/exu_params.svh ====
// --------------------
// EXU constants
// Widths, vectors and command encodings
// --------------------
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN               32
`define EXU_REG_AWIDTH         5
`define EXU_RST_VECTOR         32'h0000_0200    // First PC after reset
`define EXU_TRAP_VECTOR        32'h0000_0100    // Shared exception target
`define EXU_INSN_BYTES         4
`define EXU_INIT_DEPTH         4                // Reset-exit chain length

// --------------------
// ALU commands
// --------------------
`define EXU_ALU_ADD            4'd0
`define EXU_ALU_SUB            4'd1
`define EXU_ALU_AND            4'd2
`define EXU_ALU_OR             4'd3
`define EXU_ALU_XOR            4'd4
`define EXU_ALU_SLL            4'd5
`define EXU_ALU_SRL            4'd6
`define EXU_ALU_SRA            4'd7
`define EXU_ALU_SLT            4'd8
`define EXU_ALU_SLTU           4'd9
`define EXU_ALU_EQ             4'd10            // Branch compares from here on
`define EXU_ALU_NE             4'd11
`define EXU_ALU_LT             4'd12
`define EXU_ALU_GE             4'd13
`define EXU_ALU_LTU            4'd14
`define EXU_ALU_GEU            4'd15

// --------------------
// Write-back select
// --------------------
`define EXU_WB_NONE            3'd0
`define EXU_WB_IALU            3'd1
`define EXU_WB_SUM2            3'd2
`define EXU_WB_IMM             3'd3
`define EXU_WB_INC_PC          3'd4

// Exception codes, as in mcause
`define EXU_EXC_INSTR_MISALIGN 4'd0
`define EXU_EXC_ILLEGAL        4'd2
`define EXU_EXC_BREAKPOINT     4'd3
`define EXU_EXC_ECALL          4'd11

`endif
